//--- src/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes, RV32I base
  localparam logic [6:0] op_lui = 7'b01_101_11;
  localparam logic [6:0] op_auipc = 7'b00_101_11;
  localparam logic [6:0] op_jal = 7'b11_011_11;
  localparam logic [6:0] op_jalr = 7'b11_001_11;
  localparam logic [6:0] op_branch = 7'b11_000_11;
  localparam logic [6:0] op_reg_imm = 7'b00_100_11;
  localparam logic [6:0] op_reg_reg = 7'b01_100_11;
  localparam logic [6:0] op_environ = 7'b11_100_11;

  // funct7 selects add/sub and srl/sra
  localparam logic [6:0] f7_base = 7'b000_0000;
  localparam logic [6:0] f7_alt = 7'b010_0000;

  localparam word_t pc_step = 32'd4;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    np_seq,
    np_branch,
    np_jal,
    np_jalr
  } next_pc_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t rs2;
    reg_addr_t rs1;
    logic [2:0] funct3;
    reg_addr_t rd;
    logic [6:0] opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t rs1;
    logic [2:0] funct3;
    reg_addr_t rd;
    logic [6:0] opcode;
  } insn_i_t;

  // branch offset bits are scattered across the word
  typedef struct packed {
    logic imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t rs2;
    reg_addr_t rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic imm_11;
    logic [6:0] opcode;
  } insn_b_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t rd;
    logic [6:0] opcode;
  } insn_u_t;

  typedef struct packed {
    logic imm_20;
    logic [9:0] imm_10_1;
    logic imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t rd;
    logic [6:0] opcode;
  } insn_j_t;

  typedef union packed {
    word_t word;
    insn_r_t r;
    insn_i_t i;
    insn_b_t b;
    insn_u_t u;
    insn_j_t j;
  } insn_u;

endpackage

//--- src/rv_decode_if.sv
`timescale 1ns/1ns

interface rv_decode_if;
  import rv_pkg::*;

  alu_op_e alu_op;
  logic use_imm;
  // auipc takes the pc as operand a
  logic use_pc;
  word_t imm;
  reg_addr_t rd;
  logic reg_we;
  next_pc_e next_pc;
  logic [2:0] branch_funct3;
  logic halt_req;
  logic illegal;

  modport dec (
    output alu_op, use_imm, use_pc, imm, rd, reg_we, next_pc, branch_funct3,
    output halt_req, illegal
  );

  modport exe (input alu_op, use_imm, use_pc, imm, branch_funct3);

  modport res (input rd, reg_we, next_pc, imm, halt_req, illegal);

endinterface

//--- src/rv_decode.sv
`timescale 1ns/1ns

module rv_decode (
  input rv_pkg::word_t insn,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  rv_decode_if.dec ctrl
);
  import rv_pkg::*;

  insn_u ins;
  word_t imm_i;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  word_t shamt;

  assign ins = insn;
  assign rs1 = ins.r.rs1;
  assign rs2 = ins.r.rs2;

  // sign-extended immediates
  assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
  assign imm_b = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11, ins.b.imm_10_5,
                  ins.b.imm_4_1, 1'b0};
  assign imm_u = {ins.u.imm, 12'b0};
  assign imm_j = {{11{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12, ins.j.imm_11,
                  ins.j.imm_10_1, 1'b0};
  assign shamt = {27'b0, ins.i.imm[4:0]};

  always_comb begin
    ctrl.alu_op = alu_add;
    ctrl.use_imm = 1'b0;
    ctrl.use_pc = 1'b0;
    ctrl.imm = imm_i;
    ctrl.rd = ins.r.rd;
    ctrl.reg_we = 1'b0;
    ctrl.next_pc = np_seq;
    ctrl.branch_funct3 = ins.r.funct3;
    ctrl.halt_req = 1'b0;
    ctrl.illegal = 1'b0;

    case (ins.r.opcode)
      op_lui: begin
        ctrl.alu_op = alu_pass_b;
        ctrl.use_imm = 1'b1;
        ctrl.imm = imm_u;
        ctrl.reg_we = 1'b1;
      end
      op_auipc: begin
        ctrl.use_pc = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.imm = imm_u;
        ctrl.reg_we = 1'b1;
      end
      op_jal: begin
        ctrl.imm = imm_j;
        ctrl.reg_we = 1'b1;
        ctrl.next_pc = np_jal;
      end
      op_jalr: begin
        // target comes from the ALU sum rs1 + imm
        ctrl.use_imm = 1'b1;
        ctrl.reg_we = 1'b1;
        ctrl.next_pc = np_jalr;
        ctrl.illegal = ins.i.funct3 != 3'b000;
      end
      op_branch: begin
        ctrl.imm = imm_b;
        ctrl.next_pc = np_branch;
        ctrl.illegal = ins.b.funct3 inside {3'b010, 3'b011};
      end
      op_reg_imm: begin
        ctrl.use_imm = 1'b1;
        ctrl.reg_we = 1'b1;
        case (ins.i.funct3)
          3'b000: ctrl.alu_op = alu_add;
          3'b010: ctrl.alu_op = alu_slt;
          3'b011: ctrl.alu_op = alu_sltu;
          3'b100: ctrl.alu_op = alu_xor;
          3'b110: ctrl.alu_op = alu_or;
          3'b111: ctrl.alu_op = alu_and;
          3'b001: begin
            ctrl.alu_op = alu_sll;
            ctrl.imm = shamt;
            ctrl.illegal = ins.r.funct7 != f7_base;
          end
          default: begin
            // srli / srai, upper bits of the immediate act as funct7
            ctrl.alu_op = (ins.r.funct7 == f7_alt) ? alu_sra : alu_srl;
            ctrl.imm = shamt;
            ctrl.illegal = !(ins.r.funct7 inside {f7_base, f7_alt});
          end
        endcase
      end
      op_reg_reg: begin
        ctrl.reg_we = 1'b1;
        case (ins.r.funct3)
          3'b000: ctrl.alu_op = (ins.r.funct7 == f7_alt) ? alu_sub : alu_add;
          3'b001: ctrl.alu_op = alu_sll;
          3'b010: ctrl.alu_op = alu_slt;
          3'b011: ctrl.alu_op = alu_sltu;
          3'b100: ctrl.alu_op = alu_xor;
          3'b101: ctrl.alu_op = (ins.r.funct7 == f7_alt) ? alu_sra : alu_srl;
          3'b110: ctrl.alu_op = alu_or;
          default: ctrl.alu_op = alu_and;
        endcase
        // only add/sub and srl/sra have an alternate form
        if (ins.r.funct7 == f7_alt) begin
          ctrl.illegal = !(ins.r.funct3 inside {3'b000, 3'b101});
        end else begin
          ctrl.illegal = ins.r.funct7 != f7_base;
        end
      end
      op_environ: begin
        // ecall only, every other field zero
        if (ins.i.imm == '0 && ins.i.rs1 == '0 && ins.i.funct3 == 3'b000 && ins.i.rd == '0) begin
          ctrl.halt_req = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

//--- src/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
  input logic clk,
  input logic rst,
  input rv_pkg::reg_addr_t rs1,
  input rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t rs1_data,
  output rv_pkg::word_t rs2_data,
  input logic we,
  input rv_pkg::reg_addr_t rd,
  input rv_pkg::word_t rd_data
);
  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:31];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- src/rv_execute.sv
`timescale 1ns/1ns

module rv_execute (
  rv_decode_if.exe ctrl,
  input rv_pkg::word_t pc,
  input rv_pkg::word_t rs1_data,
  input rv_pkg::word_t rs2_data,
  output rv_pkg::word_t alu_result,
  output logic branch_taken
);
  import rv_pkg::*;

  word_t op_a;
  word_t op_b;
  logic [4:0] shamt;
  logic eq;
  logic lt_s;
  logic lt_u;

  assign op_a = ctrl.use_pc ? pc : rs1_data;
  assign op_b = ctrl.use_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_sll: alu_result = op_a << shamt;
      alu_slt: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_result = {31'b0, op_a < op_b};
      alu_xor: alu_result = op_a ^ op_b;
      alu_srl: alu_result = op_a >> shamt;
      alu_sra: alu_result = $signed(op_a) >>> shamt;
      alu_or: alu_result = op_a | op_b;
      alu_and: alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      default: alu_result = '0;
    endcase
  end

  // branch compare works on the register values, not the ALU operands
  assign eq = rs1_data == rs2_data;
  assign lt_s = $signed(rs1_data) < $signed(rs2_data);
  assign lt_u = rs1_data < rs2_data;

  always_comb begin
    case (ctrl.branch_funct3)
      3'b000: branch_taken = eq;
      3'b001: branch_taken = !eq;
      3'b100: branch_taken = lt_s;
      3'b101: branch_taken = !lt_s;
      3'b110: branch_taken = lt_u;
      3'b111: branch_taken = !lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

//--- src/rv_result.sv
`timescale 1ns/1ns

module rv_result (
  input logic clk,
  input logic rst,
  rv_decode_if.res ctrl,
  input rv_pkg::word_t alu_result,
  input logic branch_taken,
  output rv_pkg::word_t pc,
  output logic we,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t rd_data,
  output logic halt,
  output logic illegal
);
  import rv_pkg::*;

  word_t seq_pc;
  word_t target_pc;
  word_t pc_next;
  logic stop;

  assign seq_pc = pc + pc_step;
  assign target_pc = pc + ctrl.imm;
  assign stop = ctrl.halt_req | ctrl.illegal;

  always_comb begin
    case (ctrl.next_pc)
      np_branch: pc_next = branch_taken ? target_pc : seq_pc;
      np_jal: pc_next = target_pc;
      np_jalr: pc_next = {alu_result[31:1], 1'b0};
      default: pc_next = seq_pc;
    endcase
    // core freezes on ecall or a bad word
    if (stop) begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // link value for jumps
  assign rd_data = (ctrl.next_pc inside {np_jal, np_jalr}) ? seq_pc : alu_result;
  assign rd = ctrl.rd;
  assign we = ctrl.reg_we && ctrl.rd != '0 && !stop && !rst;
  assign halt = ctrl.halt_req && !rst;
  assign illegal = ctrl.illegal && !rst;

endmodule

//--- src/rv_core.sv
`timescale 1ns/1ns

module rv_core (
  input logic clk,
  input logic rst,
  output rv_pkg::word_t pc,
  input rv_pkg::word_t insn,
  output logic retire_valid,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::word_t retire_data,
  output logic halt,
  output logic illegal
);
  import rv_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_result;
  logic branch_taken;

  rv_decode_if dec_if ();

  rv_decode decode_i (
    .insn (insn),
    .rs1 (rs1),
    .rs2 (rs2),
    .ctrl (dec_if.dec)
  );

  // the retire trace is the register write port
  rv_regfile regfile_i (
    .clk (clk),
    .rst (rst),
    .rs1 (rs1),
    .rs2 (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we (retire_valid),
    .rd (retire_rd),
    .rd_data (retire_data)
  );

  rv_execute execute_i (
    .ctrl (dec_if.exe),
    .pc (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .alu_result (alu_result),
    .branch_taken (branch_taken)
  );

  rv_result result_i (
    .clk (clk),
    .rst (rst),
    .ctrl (dec_if.res),
    .alu_result (alu_result),
    .branch_taken (branch_taken),
    .pc (pc),
    .we (retire_valid),
    .rd (retire_rd),
    .rd_data (retire_data),
    .halt (halt),
    .illegal (illegal)
  );

endmodule

//--- testbench/rv_core_asserts.sv
`timescale 1ns/1ns

module rv_core_asserts (
  input logic clk,
  input logic rst,
  input rv_pkg::word_t pc,
  input logic halt,
  input logic we,
  input rv_pkg::reg_addr_t rd
);
  int fail_count = 0;

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("pc is not word-aligned");
    end

  // a halted core must not move
  halt_holds_pc: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else begin
      fail_count++;
      $error("pc moved after halt");
    end

  no_write_x0: assert property (@(posedge clk) !(we && rd == '0))
    else begin
      fail_count++;
      $error("write enable high with rd equal to x0");
    end

endmodule

bind rv_result rv_core_asserts asserts_i (
  .clk (clk),
  .rst (rst),
  .pc (pc),
  .halt (halt),
  .we (we),
  .rd (rd)
);

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb;
  import rv_pkg::*;

  localparam int prog_max = 64;
  localparam word_t ecall_word = {25'b0, op_environ};

  logic clk;
  logic rst;
  word_t pc;
  word_t insn;
  logic retire_valid;
  reg_addr_t retire_rd;
  word_t retire_data;
  logic halt;
  logic illegal;

  // instruction memory and reference state
  word_t prog [0:prog_max-1];
  int prog_len;
  word_t model_regs [0:31];
  word_t model_pc;
  int seed;
  int cycles = 0;
  int cycle_limit = 20;

  rv_core dut_i (
    .clk (clk),
    .rst (rst),
    .pc (pc),
    .insn (insn),
    .retire_valid (retire_valid),
    .retire_rd (retire_rd),
    .retire_data (retire_data),
    .halt (halt),
    .illegal (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the core did not finish its programs in %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic word_t r_type_word(input logic [6:0] f7, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input logic [2:0] f3,
                                        input reg_addr_t rd);
    insn_u w;
    w.r.funct7 = f7;
    w.r.rs2 = rs2;
    w.r.rs1 = rs1;
    w.r.funct3 = f3;
    w.r.rd = rd;
    w.r.opcode = op_reg_reg;
    return w.word;
  endfunction

  function automatic word_t i_type_word(input logic [11:0] imm, input reg_addr_t rs1,
                                        input logic [2:0] f3, input reg_addr_t rd,
                                        input logic [6:0] op);
    insn_u w;
    w.i.imm = imm;
    w.i.rs1 = rs1;
    w.i.funct3 = f3;
    w.i.rd = rd;
    w.i.opcode = op;
    return w.word;
  endfunction

  function automatic word_t branch_word(input word_t offset, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input logic [2:0] f3);
    insn_u w;
    w.b.imm_12 = offset[12];
    w.b.imm_10_5 = offset[10:5];
    w.b.rs2 = rs2;
    w.b.rs1 = rs1;
    w.b.funct3 = f3;
    w.b.imm_4_1 = offset[4:1];
    w.b.imm_11 = offset[11];
    w.b.opcode = op_branch;
    return w.word;
  endfunction

  function automatic word_t upper_word(input logic [19:0] imm, input reg_addr_t rd,
                                       input logic [6:0] op);
    insn_u w;
    w.u.imm = imm;
    w.u.rd = rd;
    w.u.opcode = op;
    return w.word;
  endfunction

  function automatic word_t jal_word(input word_t offset, input reg_addr_t rd);
    insn_u w;
    w.j.imm_20 = offset[20];
    w.j.imm_10_1 = offset[10:1];
    w.j.imm_11 = offset[11];
    w.j.imm_19_12 = offset[19:12];
    w.j.rd = rd;
    w.j.opcode = op_jal;
    return w.word;
  endfunction

  // words past the end of the program read as ecall
  function automatic word_t fetch_word(input word_t addr);
    if (addr[31:2] < 30'(prog_len)) begin
      return prog[addr[7:2]];
    end
    return ecall_word;
  endfunction

  task automatic emit(input word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // lui + addi, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input reg_addr_t rd, input word_t value);
    word_t hi;
    hi = value + 32'h800;
    emit(upper_word(hi[31:12], rd, op_lui));
    emit(i_type_word(value[11:0], rd, 3'b000, rd, op_reg_imm));
  endtask

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // RV32I reference for one instruction at model_pc
  task automatic predict(input word_t w, output logic we, output reg_addr_t rd,
                         output word_t data, output word_t next_pc,
                         output logic halt_exp, output logic ill_exp);
    logic [6:0] f7;
    logic [2:0] f3;
    word_t a;
    word_t b;
    word_t imm_i;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    logic take;
    f7 = w[31:25];
    f3 = w[14:12];
    rd = w[11:7];
    a = model_regs[w[19:15]];
    b = model_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'h000};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    we = 1'b0;
    data = '0;
    next_pc = model_pc + 32'd4;
    halt_exp = 1'b0;
    ill_exp = 1'b0;
    take = 1'b0;
    case (w[6:0])
      op_lui: begin
        we = 1'b1;
        data = imm_u;
      end
      op_auipc: begin
        we = 1'b1;
        data = model_pc + imm_u;
      end
      op_jal: begin
        we = 1'b1;
        data = model_pc + 32'd4;
        next_pc = model_pc + imm_j;
      end
      op_jalr: begin
        we = 1'b1;
        data = model_pc + 32'd4;
        next_pc = (a + imm_i) & 32'hffff_fffe;
        ill_exp = f3 != 3'b000;
      end
      op_branch: begin
        case (f3)
          3'b000: take = a == b;
          3'b001: take = a != b;
          3'b100: take = $signed(a) < $signed(b);
          3'b101: take = $signed(a) >= $signed(b);
          3'b110: take = a < b;
          3'b111: take = a >= b;
          default: ill_exp = 1'b1;
        endcase
        if (take) begin
          next_pc = model_pc + imm_b;
        end
      end
      op_reg_imm: begin
        we = 1'b1;
        data = alu_ref(f3, f3 == 3'b101 && f7 == f7_alt, a, imm_i);
        if (f3 == 3'b001) begin
          ill_exp = f7 != f7_base;
        end
        if (f3 == 3'b101) begin
          ill_exp = f7 != f7_base && f7 != f7_alt;
        end
      end
      op_reg_reg: begin
        we = 1'b1;
        data = alu_ref(f3, f7 == f7_alt, a, b);
        ill_exp = !(f7 == f7_base || (f7 == f7_alt && (f3 == 3'b000 || f3 == 3'b101)));
      end
      op_environ: begin
        halt_exp = w == ecall_word;
        ill_exp = w != ecall_word;
      end
      default: ill_exp = 1'b1;
    endcase
    if (halt_exp || ill_exp) begin
      we = 1'b0;
      next_pc = model_pc;
    end
    if (rd == 5'd0) begin
      we = 1'b0;
    end
  endtask

  task automatic reset_dut();
    rst = 1'b1;
    insn = ecall_word;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      #1;
      check_value("pc", pc, 32'd0);
      check_value("retire_valid", 32'(retire_valid), 32'd0);
      check_value("halt", 32'(halt), 32'd0);
      check_value("illegal", 32'(illegal), 32'd0);
    end
    rst = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_pc = '0;
  endtask

  // one instruction, inputs already 1 ns past the edge
  task automatic step(output logic stopped);
    word_t w;
    logic exp_we;
    reg_addr_t exp_rd;
    word_t exp_data;
    word_t exp_next;
    logic exp_halt;
    logic exp_ill;
    w = fetch_word(pc);
    insn = w;
    #10;
    predict(w, exp_we, exp_rd, exp_data, exp_next, exp_halt, exp_ill);
    check_value("pc", pc, model_pc);
    check_value("retire_valid", 32'(retire_valid), 32'(exp_we));
    if (exp_we) begin
      check_value("retire_rd", 32'(retire_rd), 32'(exp_rd));
      check_value("retire_data", retire_data, exp_data);
      model_regs[exp_rd] = exp_data;
    end
    check_value("halt", 32'(halt), 32'(exp_halt));
    check_value("illegal", 32'(illegal), 32'(exp_ill));
    model_pc = exp_next;
    stopped = exp_halt | exp_ill;
    @(posedge clk);
    #1;
  endtask

  // runs until halt or illegal, then watches the pc hold
  task automatic run_program();
    logic stopped;
    cycle_limit += prog_len + 20;
    reset_dut();
    stopped = 1'b0;
    while (!stopped) begin
      step(stopped);
    end
    repeat (3) step(stopped);
  endtask

  task automatic test_reg_imm();
    word_t a;
    word_t b;
    a = $random(seed);
    b = $random(seed) | 32'h8000_0000;
    prog_len = 0;
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit(i_type_word(12'hffb, 5'd1, 3'b000, 5'd3, op_reg_imm));
    emit(i_type_word(12'h7ff, 5'd2, 3'b010, 5'd4, op_reg_imm));
    emit(i_type_word(12'h800, 5'd1, 3'b011, 5'd5, op_reg_imm));
    emit(i_type_word(a[11:0], 5'd1, 3'b100, 5'd6, op_reg_imm));
    emit(i_type_word(12'h0f0, 5'd2, 3'b110, 5'd7, op_reg_imm));
    emit(i_type_word(b[31:20], 5'd1, 3'b111, 5'd8, op_reg_imm));
    emit(i_type_word({f7_base, a[4:0]}, 5'd1, 3'b001, 5'd9, op_reg_imm));
    emit(i_type_word({f7_base, 5'd13}, 5'd2, 3'b101, 5'd10, op_reg_imm));
    emit(i_type_word({f7_alt, 5'd13}, 5'd2, 3'b101, 5'd11, op_reg_imm));
    emit(upper_word(b[19:0], 5'd12, op_lui));
    emit(upper_word(a[31:12], 5'd13, op_auipc));
    run_program();
  endtask

  task automatic test_reg_reg();
    prog_len = 0;
    // x1 positive and x3 negative so slt and sltu disagree
    load_const(5'd1, $random(seed) & 32'h7fff_ffff);
    load_const(5'd2, $random(seed));
    load_const(5'd3, $random(seed) | 32'h8000_0000);
    emit(r_type_word(f7_base, 5'd2, 5'd1, 3'b000, 5'd4));
    emit(r_type_word(f7_alt, 5'd2, 5'd1, 3'b000, 5'd5));
    emit(r_type_word(f7_base, 5'd2, 5'd3, 3'b001, 5'd6));
    emit(r_type_word(f7_base, 5'd1, 5'd3, 3'b010, 5'd7));
    emit(r_type_word(f7_base, 5'd1, 5'd3, 3'b011, 5'd8));
    emit(r_type_word(f7_base, 5'd2, 5'd1, 3'b100, 5'd9));
    emit(r_type_word(f7_base, 5'd2, 5'd3, 3'b101, 5'd10));
    emit(r_type_word(f7_alt, 5'd2, 5'd3, 3'b101, 5'd11));
    emit(r_type_word(f7_base, 5'd2, 5'd1, 3'b110, 5'd12));
    emit(r_type_word(f7_base, 5'd3, 5'd1, 3'b111, 5'd13));
    run_program();
  endtask

  task automatic test_x0();
    prog_len = 0;
    load_const(5'd5, $random(seed));
    emit(i_type_word(12'd123, 5'd5, 3'b000, 5'd0, op_reg_imm));
    emit(r_type_word(f7_base, 5'd5, 5'd5, 3'b000, 5'd0));
    emit(upper_word(20'habcde, 5'd0, op_lui));
    emit(r_type_word(f7_base, 5'd5, 5'd0, 3'b000, 5'd6));
    emit(r_type_word(f7_alt, 5'd0, 5'd5, 3'b000, 5'd7));
    emit(r_type_word(f7_base, 5'd0, 5'd0, 3'b110, 5'd8));
    run_program();
  endtask

  // branch over one counter increment
  task automatic emit_branch_skip(input logic [2:0] f3, input reg_addr_t rs1,
                                  input reg_addr_t rs2);
    emit(branch_word(32'd8, rs2, rs1, f3));
    emit(i_type_word(12'd1, 5'd10, 3'b000, 5'd10, op_reg_imm));
  endtask

  task automatic test_branches();
    word_t a;
    a = ($random(seed) & 32'h7fff_ffff) | 32'd1;
    prog_len = 0;
    load_const(5'd1, a);
    load_const(5'd2, $random(seed) | 32'h8000_0000);
    load_const(5'd3, a);
    emit_branch_skip(3'b000, 5'd1, 5'd3);
    emit_branch_skip(3'b000, 5'd1, 5'd2);
    emit_branch_skip(3'b001, 5'd1, 5'd2);
    emit_branch_skip(3'b001, 5'd1, 5'd3);
    emit_branch_skip(3'b100, 5'd2, 5'd1);
    emit_branch_skip(3'b100, 5'd1, 5'd2);
    emit_branch_skip(3'b101, 5'd1, 5'd2);
    emit_branch_skip(3'b101, 5'd2, 5'd1);
    emit_branch_skip(3'b110, 5'd1, 5'd2);
    emit_branch_skip(3'b110, 5'd2, 5'd1);
    emit_branch_skip(3'b111, 5'd2, 5'd1);
    emit_branch_skip(3'b111, 5'd1, 5'd2);
    // jump ahead, branch back one word, then fall out
    emit(jal_word(32'd8, 5'd0));
    emit(jal_word(32'd8, 5'd0));
    emit(branch_word(32'hffff_fffc, 5'd0, 5'd0, 3'b000));
    run_program();
  endtask

  task automatic test_jumps();
    prog_len = 0;
    emit(jal_word(32'd12, 5'd5));
    emit(i_type_word(12'd1, 5'd0, 3'b000, 5'd10, op_reg_imm));
    emit(i_type_word(12'd2, 5'd0, 3'b000, 5'd10, op_reg_imm));
    emit(upper_word(20'd0, 5'd6, op_auipc));
    // odd offset, target bit 0 is cleared
    emit(i_type_word(12'd13, 5'd6, 3'b000, 5'd7, op_jalr));
    emit(i_type_word(12'd1, 5'd0, 3'b000, 5'd11, op_reg_imm));
    emit(r_type_word(f7_base, 5'd5, 5'd7, 3'b000, 5'd12));
    emit(i_type_word(12'd24, 5'd6, 3'b000, 5'd0, op_jalr));
    emit(i_type_word(12'd1, 5'd0, 3'b000, 5'd13, op_reg_imm));
    run_program();
  endtask

  task automatic test_stop();
    prog_len = 0;
    emit(i_type_word(12'd5, 5'd0, 3'b000, 5'd1, op_reg_imm));
    emit(ecall_word);
    emit(i_type_word(12'd6, 5'd0, 3'b000, 5'd1, op_reg_imm));
    run_program();
    prog_len = 0;
    emit(i_type_word(12'd7, 5'd0, 3'b000, 5'd1, op_reg_imm));
    emit(i_type_word(12'd0, 5'd0, 3'b000, 5'd1, 7'h7f));
    emit(i_type_word(12'd8, 5'd0, 3'b000, 5'd1, op_reg_imm));
    run_program();
  endtask

  initial begin
    seed = 7;
    rst = 1'b1;
    insn = ecall_word;
    prog_len = 0;
    test_reg_imm();
    test_reg_reg();
    test_x0();
    test_branches();
    test_jumps();
    test_stop();
    if (dut_i.result_i.asserts_i.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
src/rv_pkg.sv
src/rv_decode_if.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
testbench/rv_core_asserts.sv
testbench/rv_core_tb.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rv_core_tb -f verilog.f -o rv_core_sim \
  || { echo "build failed"; exit 1; }
./obj_dir/rv_core_sim > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no pass message in the log"; exit 1; }
echo "simulation passed"
